// File: source/pmu_pkg.sv
package pmu_pkg;

    // ************************************************************
    // image layout and fabric geometry
    // ************************************************************

    localparam int WORD_W        = 32;
    localparam logic [15:0] HDR_MAGIC = 16'h5AC3;
    localparam int CHAIN_WORDS   = 4;
    localparam int CHAIN_BITS    = CHAIN_WORDS * WORD_W;
    localparam int NUM_CELLS     = 8;
    localparam int CELL_CFG_BITS = 16;
    localparam int NUM_PADS_IN   = 24;

    // one NVM read every WORD_PERIOD cycles leaves room for a full word of shifts.
    localparam int WORD_PERIOD   = 36;
    localparam int ADDR_W        = 8;

    localparam int PACE_W        = $clog2(WORD_PERIOD);
    localparam int BIT_CNT_W     = $clog2(WORD_W);
    localparam int WORD_CNT_W    = $clog2(CHAIN_WORDS + 1);
    localparam int IDX_W         = $clog2(CHAIN_WORDS);

    localparam logic [ADDR_W-1:0] HDR_ADDR        = ADDR_W'(0);
    localparam logic [ADDR_W-1:0] KEY_ADDR        = ADDR_W'(1);
    localparam logic [ADDR_W-1:0] FIRST_DATA_ADDR = ADDR_W'(2);
    localparam logic [ADDR_W-1:0] LAST_ADDR       = ADDR_W'(1 + CHAIN_WORDS);

    // ************************************************************
    // stage payloads
    // ************************************************************

    typedef struct packed {
        logic [15:0] magic;
        logic [7:0]  length;
        logic [7:0]  version;
    } hdr_t;

    // the header word is decoded as fields, every other word is raw data.
    typedef union packed {
        hdr_t              hdr;
        logic [WORD_W-1:0] raw;
    } nvm_word_u;

    typedef enum logic [1:0] {
        KIND_HEADER,
        KIND_KEY,
        KIND_DATA
    } word_kind_e;

    typedef struct packed {
        logic             valid;
        word_kind_e       kind;
        logic [IDX_W-1:0] index;
        nvm_word_u        word;
    } fetch_beat_t;

    typedef struct packed {
        logic              valid;
        logic [WORD_W-1:0] word;
    } plain_beat_t;

    typedef struct packed {
        logic prog_en;
        logic ccff_head;
        logic fabric_rst_n;
        logic fabric_clk_en;
    } chain_ctrl_t;

endpackage

// File: source/nvm_fetch.sv
`timescale 1ns/1ps

module nvm_fetch (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  logic                       halt_i,
    input  logic [31:0]                mem_data_i,
    output logic [pmu_pkg::ADDR_W-1:0] mem_address_o,
    output logic                       mem_rd_o,
    output pmu_pkg::fetch_beat_t       beat_o
);

    import pmu_pkg::*;

    logic [PACE_W-1:0] pace_q;
    logic [ADDR_W-1:0] addr_q;
    logic              done_q;
    logic              rd_q;
    logic              rd_d_q;
    word_kind_e        kind_q;
    logic [IDX_W-1:0]  idx_q;

    function automatic word_kind_e addr_kind(input logic [ADDR_W-1:0] addr);
        if (addr == HDR_ADDR) begin
            return KIND_HEADER;
        end
        if (addr == KEY_ADDR) begin
            return KIND_KEY;
        end
        return KIND_DATA;
    endfunction

    // the pace counter wraps every WORD_PERIOD cycles and a read goes out at zero.
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pace_q <= '0;
            addr_q <= HDR_ADDR;
            done_q <= 1'b0;
            rd_q   <= 1'b0;
            rd_d_q <= 1'b0;
        end else begin
            rd_d_q <= rd_q;
            rd_q   <= (pace_q == '0) && !done_q && !halt_i;
            if (halt_i) begin
                done_q <= 1'b1;
            end else if (!done_q) begin
                if (pace_q == PACE_W'(WORD_PERIOD - 1)) begin
                    pace_q <= '0;
                    if (addr_q == LAST_ADDR) begin
                        done_q <= 1'b1;
                    end else begin
                        addr_q <= addr_q + 1'b1;
                    end
                end else begin
                    pace_q <= pace_q + 1'b1;
                end
            end
        end
    end

    // tag of the word that comes back on the next cycle.
    always_ff @(posedge clk) begin
        if (rd_q) begin
            kind_q <= addr_kind(addr_q);
            idx_q  <= IDX_W'(addr_q - FIRST_DATA_ADDR);
        end
    end

    assign mem_address_o = addr_q;
    assign mem_rd_o      = rd_q;

    always_comb begin
        beat_o.valid    = rd_d_q;
        beat_o.kind     = kind_q;
        beat_o.index    = idx_q;
        beat_o.word.raw = mem_data_i;
    end

    a_addr_in_image: assert property (@(posedge clk) disable iff (!rst_n_i)
        mem_rd_o |-> (mem_address_o <= LAST_ADDR))
        else $error("read issued past the end of the image");

endmodule

// File: source/bitstream_decrypt.sv
`timescale 1ns/1ps

module bitstream_decrypt (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  pmu_pkg::fetch_beat_t beat_i,
    output pmu_pkg::plain_beat_t plain_o,
    output logic                 halt_o,
    output logic                 key_ready_o,
    output logic                 locked_o
);

    import pmu_pkg::*;

    logic              hdr_ok_q;
    logic              key_ready_q;
    logic              locked_q;
    logic              plain_valid_q;
    logic [WORD_W-1:0] key_q;
    logic [WORD_W-1:0] plain_word_q;
    logic              hdr_match;
    logic              key_beat;
    logic              data_beat;

    function automatic logic [WORD_W-1:0] rotl(input logic [WORD_W-1:0] value,
                                               input logic [IDX_W-1:0]  amount);
        logic [2*WORD_W-1:0] doubled;
        doubled = {value, value} << amount;
        return doubled[2*WORD_W-1:WORD_W];
    endfunction

    // the header word is read through its field view.
    assign hdr_match = (beat_i.word.hdr.magic == HDR_MAGIC) &&
                       (beat_i.word.hdr.length == 8'(CHAIN_WORDS));

    assign key_beat  = beat_i.valid && (beat_i.kind == KIND_KEY);
    assign data_beat = beat_i.valid && (beat_i.kind == KIND_DATA);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            hdr_ok_q      <= 1'b0;
            key_ready_q   <= 1'b0;
            locked_q      <= 1'b0;
            plain_valid_q <= 1'b0;
        end else begin
            plain_valid_q <= 1'b0;
            if (beat_i.valid && !locked_q) begin
                unique case (beat_i.kind)
                    KIND_HEADER: begin
                        if (hdr_match) begin
                            hdr_ok_q <= 1'b1;
                        end else begin
                            locked_q <= 1'b1;
                        end
                    end
                    KIND_KEY: begin
                        key_ready_q <= hdr_ok_q;
                    end
                    KIND_DATA: begin
                        plain_valid_q <= key_ready_q;
                    end
                    default: begin
                        plain_valid_q <= 1'b0;
                    end
                endcase
            end
        end
    end

    // ************************************************************
    // key capture and word decryption
    // ************************************************************

    always_ff @(posedge clk) begin
        if (key_beat && hdr_ok_q) begin
            key_q <= beat_i.word.raw;
        end
        if (data_beat) begin
            plain_word_q <= beat_i.word.raw ^ rotl(key_q, beat_i.index);
        end
    end

    assign plain_o.valid = plain_valid_q;
    assign plain_o.word  = plain_word_q;

    // a rejected header stops the fetch stage for good.
    assign halt_o      = locked_q;
    assign locked_o    = locked_q;
    assign key_ready_o = key_ready_q;

    a_lock_excl: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(locked_q && key_ready_q))
        else $error("locked and key_ready both high");

endmodule

// File: source/config_chain_shifter.sv
`timescale 1ns/1ps

module config_chain_shifter (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  pmu_pkg::plain_beat_t plain_i,
    output pmu_pkg::chain_ctrl_t chain_o,
    output logic                 core_ready_o
);

    import pmu_pkg::*;

    logic [WORD_W-1:0]     shift_q;
    logic [BIT_CNT_W-1:0]  bit_cnt_q;
    logic [WORD_CNT_W-1:0] word_cnt_q;
    logic                  busy_q;
    logic                  done_q;
    logic                  last_bit;
    logic                  load;

    assign last_bit = (bit_cnt_q == BIT_CNT_W'(WORD_W - 1));
    assign load     = plain_i.valid && !busy_q && !done_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            bit_cnt_q  <= '0;
            word_cnt_q <= '0;
            busy_q     <= 1'b0;
            done_q     <= 1'b0;
        end else if (busy_q) begin
            bit_cnt_q <= bit_cnt_q + 1'b1;
            if (last_bit) begin
                busy_q     <= 1'b0;
                word_cnt_q <= word_cnt_q + 1'b1;
                // the final word releases the fabric on the next cycle.
                if (word_cnt_q == WORD_CNT_W'(CHAIN_WORDS - 1)) begin
                    done_q <= 1'b1;
                end
            end
        end else if (load) begin
            busy_q    <= 1'b1;
            bit_cnt_q <= '0;
        end
    end

    // words go out least significant bit first.
    always_ff @(posedge clk) begin
        if (load) begin
            shift_q <= plain_i.word;
        end else if (busy_q) begin
            shift_q <= shift_q >> 1;
        end
    end

    always_comb begin
        chain_o.prog_en       = busy_q;
        chain_o.ccff_head     = shift_q[0];
        chain_o.fabric_rst_n  = done_q;
        chain_o.fabric_clk_en = done_q;
    end

    assign core_ready_o = done_q;

    a_no_prog_when_ready: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(chain_o.prog_en && core_ready_o))
        else $error("chain still programming after core_ready");

    // the fetch pace must leave the shifter idle whenever a word arrives.
    a_idle_on_arrival: assert property (@(posedge clk) disable iff (!rst_n_i)
        plain_i.valid |-> !busy_q)
        else $error("plain word arrived while shifting");

endmodule

// File: source/fabric_core.sv
`timescale 1ns/1ps

module fabric_core (
    input  logic                            clk,
    input  logic                            rst_n_i,
    input  pmu_pkg::chain_ctrl_t            chain_i,
    input  logic [pmu_pkg::NUM_PADS_IN-1:0] pad_i,
    output logic [pmu_pkg::NUM_CELLS-1:0]   pad_o
);

    import pmu_pkg::*;

    logic [CHAIN_BITS-1:0]                    chain_q;
    logic [NUM_CELLS-1:0][CELL_CFG_BITS-1:0] cell_cfg;
    logic [NUM_CELLS-1:0]                     cell_d;
    logic [NUM_CELLS-1:0]                     cell_q;

    // ************************************************************
    // configuration chain
    // ************************************************************

    // the head bit enters at the top, so the first bit shifted ends up in bit 0.
    always_ff @(posedge clk) begin
        if (chain_i.prog_en) begin
            chain_q <= {chain_i.ccff_head, chain_q[CHAIN_BITS-1:1]};
        end
    end

    // cell k owns chain bits 16k up to 16k+15.
    assign cell_cfg = chain_q;

    // ************************************************************
    // LUT4 cells
    // ************************************************************

    for (genvar k = 0; k < NUM_CELLS; k++) begin : g_cell
        logic       prev_out;
        logic [3:0] lut_idx;

        if (k == 0) begin : g_first
            assign prev_out = 1'b0;
        end else begin : g_chain
            assign prev_out = cell_q[k-1];
        end

        assign lut_idx   = {prev_out, pad_i[3*k+2], pad_i[3*k+1], pad_i[3*k]};
        assign cell_d[k] = cell_cfg[k][lut_idx];
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i || !chain_i.fabric_rst_n) begin
            cell_q <= '0;
        end else if (chain_i.fabric_clk_en) begin
            cell_q <= cell_d;
        end
    end

    assign pad_o = cell_q;

    a_pads_quiet_in_reset: assert property (@(posedge clk) disable iff (!rst_n_i)
        !chain_i.fabric_rst_n |-> (pad_o == '0))
        else $error("fabric outputs active while the fabric is held in reset");

endmodule

// File: source/pmu_fpga_top.sv
`timescale 1ns/1ps

module pmu_fpga_top (
    input  logic                            clk,
    input  logic                            rst_n_i,
    input  logic [31:0]                     mem_data_i,
    output logic [pmu_pkg::ADDR_W-1:0]      mem_address_o,
    output logic                            mem_rd_o,
    output logic                            key_ready_o,
    output logic                            core_ready_o,
    output logic                            locked_o,
    input  logic [pmu_pkg::NUM_PADS_IN-1:0] fpga_pad_i,
    output logic [pmu_pkg::NUM_CELLS-1:0]   fpga_pad_o
);

    import pmu_pkg::*;

    fetch_beat_t fetch_beat;
    plain_beat_t plain_beat;
    chain_ctrl_t chain_ctrl;
    logic        halt;

    // ************************************************************
    // fetch, decrypt, shift, fabric
    // ************************************************************

    nvm_fetch u_fetch (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .halt_i        (halt),
        .mem_data_i    (mem_data_i),
        .mem_address_o (mem_address_o),
        .mem_rd_o      (mem_rd_o),
        .beat_o        (fetch_beat)
    );

    bitstream_decrypt u_decrypt (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .beat_i      (fetch_beat),
        .plain_o     (plain_beat),
        .halt_o      (halt),
        .key_ready_o (key_ready_o),
        .locked_o    (locked_o)
    );

    config_chain_shifter u_shifter (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .plain_i      (plain_beat),
        .chain_o      (chain_ctrl),
        .core_ready_o (core_ready_o)
    );

    fabric_core u_fabric (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .chain_i (chain_ctrl),
        .pad_i   (fpga_pad_i),
        .pad_o   (fpga_pad_o)
    );

endmodule

// File: verification/pmu_fpga_tb.sv
`timescale 1ns/1ps

module pmu_fpga_tb;

    import pmu_pkg::*;

    logic                   clk;
    logic                   rst_n_i;
    logic [31:0]            mem_data_i;
    logic [ADDR_W-1:0]      mem_address_o;
    logic                   mem_rd_o;
    logic                   key_ready_o;
    logic                   core_ready_o;
    logic                   locked_o;
    logic [NUM_PADS_IN-1:0] fpga_pad_i;
    logic [NUM_CELLS-1:0]   fpga_pad_o;

    logic [31:0]            nvm [0:(1<<ADDR_W)-1];
    logic                   rd_pending;
    logic [ADDR_W-1:0]      rd_addr;
    logic [31:0]            lfsr_state;
    logic [CHAIN_BITS-1:0]  exp_table;
    logic                   expect_good;
    logic                   expect_lock;
    int                     rd_count;

    pmu_fpga_top dut_i (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .mem_data_i    (mem_data_i),
        .mem_address_o (mem_address_o),
        .mem_rd_o      (mem_rd_o),
        .key_ready_o   (key_ready_o),
        .core_ready_o  (core_ready_o),
        .locked_o      (locked_o),
        .fpga_pad_i    (fpga_pad_i),
        .fpga_pad_o    (fpga_pad_o)
    );

    always #2 clk = ~clk;

    // the NVM answers on the cycle after the read strobe.
    always @(negedge clk) begin
        if (rd_pending) begin
            mem_data_i <= nvm[rd_addr];
        end
        rd_pending <= mem_rd_o;
        rd_addr    <= mem_address_o;
    end

    always @(posedge clk) begin
        if (!rst_n_i) begin
            rd_count <= 0;
        end else if (mem_rd_o) begin
            rd_count <= rd_count + 1;
        end
    end

    // ************************************************************
    // reference helpers
    // ************************************************************

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value      = {value[30:0], lfsr_state[0]};
        end
    endtask

    function automatic logic [NUM_CELLS-1:0] lut_outputs(input logic [CHAIN_BITS-1:0] tables,
                                                         input logic [NUM_PADS_IN-1:0] pads,
                                                         input logic [NUM_CELLS-1:0] prev);
        logic [NUM_CELLS-1:0] outs;
        logic [3:0]           idx;
        for (int k = 0; k < NUM_CELLS; k++) begin
            idx     = {(k == 0) ? 1'b0 : prev[k-1], pads[3*k+2], pads[3*k+1], pads[3*k]};
            outs[k] = tables[CELL_CFG_BITS*k + idx];
        end
        return outs;
    endfunction

    // fills the NVM and works out the chain that a good load must leave behind.
    task automatic build_image(input logic [15:0] magic, input logic [7:0] length);
        logic [31:0] key;
        logic [31:0] data;
        logic [31:0] rot;
        for (int a = 0; a < (1 << ADDR_W); a++) begin
            nvm[a] = {~a[7:0], a[7:0], a[7:0] ^ 8'h3c, a[7:0]};
        end
        nvm[0] = {magic, length, 8'h01};
        take_bits(32, key);
        nvm[1] = key;
        rot    = key;
        for (int i = 0; i < CHAIN_WORDS; i++) begin
            take_bits(32, data);
            nvm[2+i]                 = data;
            exp_table[32*i +: 32]    = data ^ rot;
            rot                      = {rot[30:0], rot[31]};
        end
    endtask

    task automatic start_load(input logic good, input logic [15:0] magic,
                              input logic [7:0] length);
        @(negedge clk);
        rst_n_i     = 1'b0;
        fpga_pad_i  = '0;
        expect_good = good;
        expect_lock = !good;
        build_image(magic, length);
        repeat (3) @(negedge clk);
        rst_n_i = 1'b1;
    endtask

    task automatic report_error(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        $display("Testbench failed");
        $fatal(1);
    endtask

    // ************************************************************
    // checks
    // ************************************************************

    a_addr_order: assert property (@(posedge clk) disable iff (!rst_n_i)
        mem_rd_o |-> (mem_address_o == ADDR_W'(rd_count)) && (rd_count <= CHAIN_WORDS + 1))
        else report_error("NVM read address out of order");

    a_no_read_when_locked: assert property (@(posedge clk) disable iff (!rst_n_i)
        (expect_lock && mem_rd_o) |-> (rd_count == 0))
        else report_error("read past the header of a rejected image");

    a_all_words_read: assert property (@(posedge clk) disable iff (!rst_n_i)
        $rose(core_ready_o) |-> (rd_count == CHAIN_WORDS + 2))
        else report_error("core_ready rose before every image word was read");

    a_key_first: assert property (@(posedge clk) disable iff (!rst_n_i)
        core_ready_o |-> key_ready_o)
        else report_error("core_ready high without key_ready");

    a_good_not_locked: assert property (@(posedge clk) disable iff (!rst_n_i)
        expect_good |-> !locked_o)
        else report_error("locked raised for a valid image");

    a_bad_stays_idle: assert property (@(posedge clk) disable iff (!rst_n_i)
        expect_lock |-> (!key_ready_o && !core_ready_o))
        else report_error("key_ready or core_ready raised for a rejected image");

    a_pads_zero: assert property (@(posedge clk) disable iff (!rst_n_i)
        !core_ready_o |-> (fpga_pad_o == '0))
        else report_error("fpga_pad_o not zero before core_ready");

    a_cell_lookup: assert property (@(posedge clk) disable iff (!rst_n_i)
        (core_ready_o && $past(core_ready_o)) |->
            (fpga_pad_o == lut_outputs(exp_table, $past(fpga_pad_i), $past(fpga_pad_o))))
        else report_error("fpga_pad_o differs from the LUT lookup");

    // three loads, the pad phase and some slack.
    initial begin
        int limit;
        limit = 3 * ((CHAIN_WORDS + 2) * WORD_PERIOD + 2 * WORD_W + 8) + 200 + 100;
        repeat (limit) @(posedge clk);
        $display("Watchdog expired, configuration never completed in time");
        $display("Testbench failed");
        $fatal(1);
    end

    initial begin
        logic [31:0] pads;
        clk         = 1'b0;
        rst_n_i     = 1'b0;
        mem_data_i  = '0;
        fpga_pad_i  = '0;
        rd_pending  = 1'b0;
        rd_addr     = '0;
        expect_good = 1'b0;
        expect_lock = 1'b0;
        exp_table   = '0;
        lfsr_state  = 32'hded910a7;

        start_load(1'b1, HDR_MAGIC, 8'(CHAIN_WORDS));
        while (!core_ready_o) begin
            @(negedge clk);
        end
        repeat (200) begin
            @(negedge clk);
            take_bits(NUM_PADS_IN, pads);
            fpga_pad_i = pads[NUM_PADS_IN-1:0];
        end

        start_load(1'b0, HDR_MAGIC ^ 16'h0100, 8'(CHAIN_WORDS));
        while (!locked_o) begin
            @(negedge clk);
        end
        repeat (2 * WORD_PERIOD) @(negedge clk);

        start_load(1'b0, HDR_MAGIC, 8'(CHAIN_WORDS + 1));
        while (!locked_o) begin
            @(negedge clk);
        end
        repeat (2 * WORD_PERIOD) @(negedge clk);

        $display("Testbench passed");
        $finish;
    end

endmodule

// File: filelist.f
source/pmu_pkg.sv
source/nvm_fetch.sv
source/bitstream_decrypt.sv
source/config_chain_shifter.sv
source/fabric_core.sv
source/pmu_fpga_top.sv
verification/pmu_fpga_tb.sv
